// ==== files.f ====
+incdir+hw
hw/led_pkg.sv
hw/led_reg_port.sv
hw/disp_fifo.sv
hw/seg7_display.sv
hw/led_display_top.sv
sim/tb_led_display.sv

// ==== hw/disp_fifo.sv ====
`timescale 1ns/1ns
`include "led_defines.svh"

// ==============================
// display word buffer
// ==============================
module disp_fifo
    import led_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_req,     // from led_reg_port
    output logic       in_ack,
    input  disp_word_t in_word,
    output logic       out_req,    // to seg7_display
    input  logic       out_ack,
    output disp_word_t out_word
);

    localparam int DEPTH = `DISP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    disp_word_t       mem [DEPTH];   // circular storage
    logic [PTR_W-1:0] wr_ptr;        // wraps naturally, power of two
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;         // entries held
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    hs_state_e        out_state;     // output side sender

    assign full  = (count == (PTR_W+1)'(DEPTH));
    assign empty = (count == '0);

    // new word only while ack low, so one store per req
    assign push = in_req && !in_ack && !full;
    assign pop  = (out_state == HS_REQ) && out_ack;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // pointers, count and receiver ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            in_ack <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                in_ack <= 1'b1;     // stored, tell sender
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;     // req seen low
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // ==============================
    // output side sender
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_state <= HS_IDLE;
        end else begin
            case (out_state)
                HS_IDLE:    out_state <= empty ? HS_IDLE : HS_REQ;
                HS_REQ:     out_state <= out_ack ? HS_RELEASE : HS_REQ;  // pop here
                HS_RELEASE: out_state <= out_ack ? HS_RELEASE : HS_IDLE;
                default:    out_state <= HS_IDLE;
            endcase
        end
    end

    assign out_req  = (out_state == HS_REQ);
    assign out_word = mem[rd_ptr];   // head entry

endmodule

// ==== hw/led_defines.svh ====
`ifndef LED_DEFINES_SVH
`define LED_DEFINES_SVH

// ==============================
// led / display sizing
// ==============================

// width of the led export value, same as the cpu data bus
`define LED_WORD_W 32

// seven-segment digits on the board, one nibble each
`define HEX_DIGITS 8

// display buffer entries, power of two, 2 or more
`define DISP_FIFO_DEPTH 4

`endif

// ==== hw/led_display_top.sv ====
`timescale 1ns/1ns
`include "led_defines.svh"

// ==============================
// led / seven-segment output path
// ==============================
module led_display_top
    import led_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wr_en,      // cpu side
    input  led_wr_t                      wr_cmd,
    output logic                         wr_ready,
    input  logic                         hold,       // display freeze
    output logic [`HEX_DIGITS-1:0][6:0]  hex,
    output logic [17:0]                  ledr,
    output logic [8:0]                   ledg
);

    logic       in_req;     // producer -> buffer
    logic       in_ack;
    disp_word_t in_word;
    logic       out_req;    // buffer -> display
    logic       out_ack;
    disp_word_t out_word;

    led_reg_port u_reg_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_cmd   (wr_cmd),
        .wr_ready (wr_ready),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_word  (in_word)
    );

    disp_fifo u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_word  (in_word),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_word (out_word)
    );

    seg7_display u_display (
        .clk      (clk),
        .arst_n   (arst_n),
        .hold     (hold),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_word (out_word),
        .hex      (hex),
        .ledr     (ledr),
        .ledg     (ledg)
    );

endmodule

// ==== hw/led_pkg.sv ====
`include "led_defines.svh"

// ==============================
// led output path types
// ==============================
package led_pkg;

    // write opcode carried with each cpu write
    typedef enum logic [1:0] {
        OP_WRITE  = 2'b00,  // replace
        OP_SET    = 2'b01,  // or in
        OP_CLEAR  = 2'b10,  // clear where data is one
        OP_TOGGLE = 2'b11   // xor in
    } led_op_e;

    // cpu-side write command, op on top
    typedef struct packed {
        led_op_e                op;
        logic [`LED_WORD_W-1:0] data;
    } led_wr_t;

    // value shipped to the display
    typedef logic [`LED_WORD_W-1:0] disp_word_t;

    // four-phase sender half
    typedef enum logic [1:0] {
        HS_IDLE    = 2'b00,  // nothing offered
        HS_REQ     = 2'b01,  // req high, waiting for ack
        HS_RELEASE = 2'b10   // req dropped, waiting for ack low
    } hs_state_e;

endpackage

// ==== hw/led_reg_port.sv ====
`timescale 1ns/1ns

// ==============================
// cpu-side led export register
// ==============================
module led_reg_port
    import led_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_en,      // cpu write strobe
    input  led_wr_t    wr_cmd,     // opcode + data
    output logic       wr_ready,   // high only when idle
    output logic       in_req,     // to buffer
    input  logic       in_ack,     // from buffer
    output disp_word_t in_word     // shadow value on offer
);

    hs_state_e  state_q;    // sender half
    disp_word_t shadow_q;   // led export shadow
    disp_word_t shadow_nxt;
    logic       wr_fire;    // write taken this edge

    assign wr_ready = (state_q == HS_IDLE);
    assign wr_fire  = wr_en && wr_ready;

    // opcode applied to current shadow
    always_comb begin
        case (wr_cmd.op)
            OP_WRITE:  shadow_nxt = wr_cmd.data;
            OP_SET:    shadow_nxt = shadow_q | wr_cmd.data;
            OP_CLEAR:  shadow_nxt = shadow_q & ~wr_cmd.data;
            OP_TOGGLE: shadow_nxt = shadow_q ^ wr_cmd.data;
            default:   shadow_nxt = shadow_q;
        endcase
    end

    // shadow only moves on an accepted write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow_q <= '0;   // all leds off
        end else if (wr_fire) begin
            shadow_q <= shadow_nxt;
        end
    end

    // ==============================
    // four-phase sender
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= HS_IDLE;
        end else begin
            case (state_q)
                HS_IDLE: begin
                    if (wr_fire) begin
                        state_q <= HS_REQ;      // req up next cycle
                    end
                end
                HS_REQ: begin
                    if (in_ack) begin
                        state_q <= HS_RELEASE;  // word stored, drop req
                    end
                end
                HS_RELEASE: begin
                    if (!in_ack) begin
                        state_q <= HS_IDLE;     // ack back low, link free
                    end
                end
                default: state_q <= HS_IDLE;
            endcase
        end
    end

    assign in_req  = (state_q == HS_REQ);
    assign in_word = shadow_q;   // stable from accept until idle again

endmodule

// ==== hw/seg7_display.sv ====
`timescale 1ns/1ns
`include "led_defines.svh"

// ==============================
// seven-segment and led consumer
// ==============================
module seg7_display
    import led_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         hold,      // freeze switch
    input  logic                         out_req,   // from buffer
    output logic                         out_ack,
    input  disp_word_t                   out_word,
    output logic [`HEX_DIGITS-1:0][6:0]  hex,       // active low, digit 0 = bits 3:0
    output logic [17:0]                  ledr,
    output logic [8:0]                   ledg
);

    // hex glyphs, segment g on bit 6, active low
    localparam logic [6:0] GLYPH [16] = '{
        7'b1000000,   // 0
        7'b1111001,   // 1
        7'b0100100,   // 2
        7'b0110000,   // 3
        7'b0011001,   // 4
        7'b0010010,   // 5
        7'b0000010,   // 6
        7'b1111000,   // 7
        7'b0000000,   // 8
        7'b0010000,   // 9
        7'b0001000,   // a
        7'b0000011,   // b
        7'b1000110,   // c
        7'b0100001,   // d
        7'b0000110,   // e
        7'b0001110    // f
    };

    disp_word_t shown_q;   // value on the display
    logic       take;      // accept this edge

    // hold keeps ack low, buffer backs up behind us
    assign take = out_req && !out_ack && !hold;

    // ==============================
    // four-phase receiver
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shown_q <= '0;      // all zeros shown
            out_ack <= 1'b0;
        end else if (take) begin
            shown_q <= out_word;
            out_ack <= 1'b1;    // same edge as latch
        end else if (out_ack && !out_req) begin
            out_ack <= 1'b0;    // one cycle after req falls
        end
    end

    // nibble per digit
    always_comb begin
        for (int i = 0; i < `HEX_DIGITS; i++) begin
            hex[i] = GLYPH[shown_q[4*i +: 4]];
        end
    end

    // low 27 bits to the leds, green on the bottom
    assign ledg = shown_q[8:0];
    assign ledr = shown_q[26:9];

endmodule

// ==== sim/tb_led_display.sv ====
`timescale 1ns/1ns
`include "led_defines.svh"

module tb_led_display
    import led_pkg::*;
();

    typedef logic [`HEX_DIGITS*7+27-1:0] disp_bus_t;   // {hex, ledr, ledg}

    localparam int WAIT_LIMIT = 200;   // cycles per wait loop
    localparam logic [6:0] GLYPH_REF [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic                        clk;
    logic                        arst_n;
    logic                        wr_en;
    led_wr_t                     wr_cmd;
    logic                        wr_ready;
    logic                        hold;
    logic [`HEX_DIGITS-1:0][6:0] hex;
    logic [17:0]                 ledr;
    logic [8:0]                  ledg;
    disp_bus_t                   disp_bus;
    disp_bus_t                   last_bus;
    disp_bus_t                   seen [$];   // every display change in order
    disp_word_t                  model;      // expected shadow value
    disp_word_t                  sent [$];
    int                          errors = 0;
    int                          checks = 0;

    led_display_top DUT (.*);

    assign disp_bus = {hex, ledr, ledg};

    always #5 clk = ~clk;

    // record the display whenever it moves
    always @(posedge clk) begin
        if (!arst_n) begin
            last_bus = disp_bus;
        end else if (disp_bus !== last_bus) begin
            seen.push_back(disp_bus);
            last_bus = disp_bus;
        end
    end

    // ==============================
    // link protocol checks
    // ==============================
    display_once_per_word: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(disp_bus) |-> $rose(DUT.out_ack))
        else begin
            $display("[FAIL] %0t: display moved without a new ack", $time);
            errors++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(DUT.out_ack) |-> $past(DUT.out_req))
        else begin
            $display("[FAIL] %0t: out_ack rose with out_req low", $time);
            errors++;
        end

    req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(DUT.out_req) |-> !$past(DUT.out_ack))
        else begin
            $display("[FAIL] %0t: out_req rose before out_ack returned low", $time);
            errors++;
        end

    // opcode rules
    function automatic disp_word_t apply_op(disp_word_t cur, led_op_e op, disp_word_t d);
        case (op)
            OP_WRITE: return d;
            OP_SET:   return cur | d;
            OP_CLEAR: return cur & ~d;
            default:  return cur ^ d;
        endcase
    endfunction

    // what the board should show for a value
    function automatic disp_bus_t render(disp_word_t v);
        logic [`HEX_DIGITS-1:0][6:0] h;
        for (int i = 0; i < `HEX_DIGITS; i++) h[i] = GLYPH_REF[v[4*i +: 4]];
        return {h, v[26:9], v[8:0]};
    endfunction

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic do_write(input led_op_e op, input disp_word_t data);
        int waited = 0;
        while (!wr_ready) begin
            if (waited == WAIT_LIMIT) abort_run("wr_ready stayed low, write not accepted");
            @(posedge clk);
            #1;
            waited++;
        end
        wr_cmd = '{op: op, data: data};
        wr_en  = 1'b1;
        @(posedge clk);   // accepted here
        #1;
        wr_en  = 1'b0;
        model  = apply_op(model, op, data);
    endtask

    task automatic wait_change(input int n);
        int waited = 0;
        while (seen.size() <= n) begin
            if (waited == WAIT_LIMIT) abort_run("display never changed after a write");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // producer idle, buffer empty, display link at rest
    task automatic wait_drain();
        int waited = 0;
        while (!(wr_ready && DUT.u_fifo.count == 0 && !DUT.out_req && !DUT.out_ack)) begin
            if (waited == WAIT_LIMIT) abort_run("write stream did not drain");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "errors seen");
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        int e;
        int n;
        int k;
        led_op_e op;
        clk    = 1'b0;
        arst_n = 1'b1;
        wr_en  = 1'b0;
        wr_cmd = '0;
        hold   = 1'b0;
        model  = '0;
        void'($urandom(46));
        #2 arst_n = 1'b0;   // clean falling edge
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;

        e = errors;
        check_value(wr_ready, 1'b1, "wr_ready after reset");
        check_value(ledr, '0, "ledr after reset");
        check_value(ledg, '0, "ledg after reset");
        for (int i = 0; i < `HEX_DIGITS; i++) check_value(hex[i], GLYPH_REF[0], "hex digit");
        report_test("reset", e);

        e = errors;
        sent = '{32'h0000_f0f0, 32'h0f00_000f, 32'h0000_00ff, 32'hffff_0000};
        for (int i = 0; i < 4; i++) begin
            n = seen.size();
            do_write(led_op_e'(i), sent[i]);   // write, set, clear, toggle
            wait_change(n);
            check_value(seen[$], render(model), "display after opcode");
        end
        report_test("opcodes", e);

        e = errors;
        sent = '{32'h0123_4567, 32'h89ab_cdef};
        foreach (sent[j]) begin
            n = seen.size();
            do_write(OP_WRITE, sent[j]);
            wait_change(n);
            for (int i = 0; i < `HEX_DIGITS; i++)
                check_value(hex[i], GLYPH_REF[sent[j][4*i +: 4]], "decoded digit");
            check_value(ledr, sent[j][26:9], "ledr field");
            check_value(ledg, sent[j][8:0], "ledg field");
        end
        report_test("decode", e);

        // ==============================
        // back-pressure with hold
        // ==============================
        e = errors;
        wait_drain();
        hold = 1'b1;
        n = seen.size();
        sent.delete();
        for (int i = 0; i < `DISP_FIFO_DEPTH + 1; i++) begin
            do_write(OP_WRITE, 32'hc0de_0000 + i);
            sent.push_back(model);
        end
        repeat (20) begin   // last write must stall
            @(posedge clk);
            #1;
            check_value(wr_ready, 1'b0, "wr_ready under hold");
        end
        check_value(seen.size(), n, "display changes under hold");
        hold = 1'b0;
        do_write(OP_WRITE, 32'hc0de_00ff);
        sent.push_back(model);
        wait_drain();
        check_value(seen.size(), n + sent.size(), "display change count");
        foreach (sent[i])
            if (n + i < seen.size()) check_value(seen[n+i], render(sent[i]), "ordered value");
        check_value(disp_bus, render(model), "display after release");
        report_test("backpressure", e);

        e = errors;
        for (int i = 0; i < 40; i++) begin
            op = led_op_e'($urandom_range(3, 0));
            if ($urandom_range(3, 0) == 0) begin   // short freeze pulse
                hold = 1'b1;
                k = $urandom_range(6, 1);
                repeat (k) @(posedge clk);
                #1 hold = 1'b0;
            end
            do_write(op, $urandom);
        end
        wait_drain();
        check_value(disp_bus, render(model), "display after random stream");
        report_test("random", e);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
